/* files.f */
hw/digit_pad_pkg.sv
hw/mouse_event_if.sv
hw/raster_if.sv
hw/ps2_packet_decoder.sv
hw/sketch_canvas.sv
hw/vga_raster.sv
hw/canvas_overlay.sv
hw/digit_pad_top.sv
bench/tb_digit_pad.sv

/* Makefile */
# Verilator build for the digit pad testbench

VERILATOR  ?= verilator
TOP        ?= tb_digit_pad
RTL_TOP    ?= digit_pad_top
FILELIST   ?= files.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
JOBS       ?= 0
SIM_FLAGS  ?= --binary --timing --assert -Wno-fatal -j $(JOBS)
LINT_FLAGS ?= --lint-only --timing -Wall

.PHONY: all lint sim build clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) -Mdir $(BUILD_DIR)

sim: build
	./$(BUILD_DIR)/V$(TOP) 2>&1 | tee $(LOG)
	@if grep -q "Simulation FAILED" $(LOG); then \
		echo "failure found in $(LOG)"; \
		exit 1; \
	fi
	@if ! grep -q "Simulation PASSED" $(LOG); then \
		echo "no result line in $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* bench/tb_digit_pad.sv */
`timescale 1ns/1ns

module tb_digit_pad;

    // small raster and grid keep each frame short
    localparam int H_ACTIVE     = 64;
    localparam int H_FRONT      = 2;
    localparam int H_SYNC       = 4;
    localparam int H_BACK       = 2;
    localparam int V_ACTIVE     = 48;
    localparam int V_FRONT      = 1;
    localparam int V_SYNC       = 2;
    localparam int V_BACK       = 1;
    localparam int H_TOTAL      = H_ACTIVE + H_FRONT + H_SYNC + H_BACK;
    localparam int V_TOTAL      = V_ACTIVE + V_FRONT + V_SYNC + V_BACK;
    localparam int CANVAS_DIM   = 16;
    localparam int CELL_SHIFT   = 1;
    localparam int MOTION_SHIFT = 2;
    localparam int RESET_CYCLES = 16;
    // ps2 bit is two half periods of the device clock
    localparam int PS2_HALF     = 20;
    localparam int NUM_PACKETS  = 23;
    // a frame check may cost nearly two frame periods
    localparam int NUM_FRAMES   = 8;
    localparam int TIMEOUT_CYCLES =
        (NUM_PACKETS * 33 * 40 + NUM_FRAMES * H_TOTAL * V_TOTAL) * 3 / 2;

    // expected colours as rgb
    localparam logic [23:0] INK_RGB        = 24'hffffff;
    localparam logic [23:0] CURSOR_RGB     = 24'hff0000;
    localparam logic [23:0] PAPER_RGB      = 24'h282828;
    localparam logic [23:0] BACKGROUND_RGB = 24'h000000;

    logic       clk;
    logic       reset;
    logic       ps2_clk;
    logic       ps2_data;
    logic [7:0] vga_r;
    logic [7:0] vga_g;
    logic [7:0] vga_b;
    logic       vga_hs;
    logic       vga_vs;
    logic       vga_blank_n;
    logic [3:0] cursor_x;
    logic [3:0] cursor_y;
    logic       ps2_error;

    int          error_count;
    int          check_count;
    int          strobe_count;
    int          error_pulse_count;
    int          cycle_count;
    logic [31:0] lfsr_state;
    // scoreboard copy of cursor and ink
    int          model_x;
    int          model_y;
    logic        model_ink [CANVAS_DIM*CANVAS_DIM];

    digit_pad_top #(
        .CANVAS_DIM   (CANVAS_DIM),
        .CELL_SHIFT   (CELL_SHIFT),
        .MOTION_SHIFT (MOTION_SHIFT),
        .H_ACTIVE     (H_ACTIVE),
        .H_FRONT      (H_FRONT),
        .H_SYNC       (H_SYNC),
        .H_BACK       (H_BACK),
        .V_ACTIVE     (V_ACTIVE),
        .V_FRONT      (V_FRONT),
        .V_SYNC       (V_SYNC),
        .V_BACK       (V_BACK)
    ) i_digit_pad_top (
        .i_clk         (clk),
        .i_reset       (reset),
        .i_ps2_clk     (ps2_clk),
        .i_ps2_data    (ps2_data),
        .o_vga_r       (vga_r),
        .o_vga_g       (vga_g),
        .o_vga_b       (vga_b),
        .o_vga_hs      (vga_hs),
        .o_vga_vs      (vga_vs),
        .o_vga_blank_n (vga_blank_n),
        .o_cursor_x    (cursor_x),
        .o_cursor_y    (cursor_y),
        .o_ps2_error   (ps2_error)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // watchdog on the total test length
    initial begin
        cycle_count = 0;
        while (cycle_count < TIMEOUT_CYCLES) begin
            @(posedge clk);
            cycle_count++;
        end
        $display("run stopped, no result after %0d cycles", cycle_count);
        $display("Simulation FAILED");
        $finish;
    end

    // count decoder events and frame errors between edges
    always @(negedge clk) begin
        if (i_digit_pad_top.mouse_events.strobe === 1'b1) begin
            strobe_count++;
        end
        if (ps2_error === 1'b1) begin
            error_pulse_count++;
        end
    end

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        check_count++;
        if (actual !== expected) begin
            error_count++;
            $display("FAIL %0t ns %s got %0h expected %0h", $time, name, actual, expected);
        end
    endtask

    // inputs change 1 ns after the rising edge
    task automatic wait_cycles(input int count);
        repeat (count) @(posedge clk);
        #1;
    endtask

    // galois lfsr over x^32 + x^22 + x^2 + x + 1 stepped once per bit
    function automatic logic next_random_bit();
        logic out_bit;
        out_bit = lfsr_state[0];
        lfsr_state = lfsr_state >> 1;
        if (out_bit) begin
            lfsr_state = lfsr_state ^ 32'h8020_0003;
        end
        return out_bit;
    endfunction

    function automatic logic signed [8:0] random_motion();
        logic [8:0] value;
        for (int i = 0; i < 9; i++) begin
            value[i] = next_random_bit();
        end
        return value;
    endfunction

    function automatic int clamp_cell(input int value);
        if (value < 0) begin
            return 0;
        end
        if (value > CANVAS_DIM - 1) begin
            return CANVAS_DIM - 1;
        end
        return value;
    endfunction

    // shift and move with y flipped and clamped before clear or paint
    task automatic apply_model(input logic signed [8:0] dx, input logic signed [8:0] dy,
                               input logic left, input logic right);
        int step_x;
        int step_y;
        step_x  = dx;
        step_y  = dy;
        model_x = clamp_cell(model_x + (step_x >>> MOTION_SHIFT));
        model_y = clamp_cell(model_y - (step_y >>> MOTION_SHIFT));
        if (right) begin
            foreach (model_ink[i]) model_ink[i] = 1'b0;
        end else if (left) begin
            model_ink[model_y * CANVAS_DIM + model_x] = 1'b1;
        end
    endtask

    // start 0, data lsb first, odd parity, stop 1
    task automatic send_frame(input logic [7:0] data, input logic bad_parity);
        logic [10:0] bits;
        logic        parity;
        parity = ~(^data);
        if (bad_parity) begin
            parity = ~parity;
        end
        bits = {1'b1, parity, data, 1'b0};
        for (int i = 0; i < 11; i++) begin
            // data settles while the clock is high
            ps2_data = bits[i];
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b0;
            wait_cycles(PS2_HALF);
            ps2_clk = 1'b1;
        end
    endtask

    // header carries buttons in 1:0, always-one bit 3 and sign bits in 5:4
    task automatic send_packet(input logic signed [8:0] dx, input logic signed [8:0] dy,
                               input logic left, input logic right, input logic corrupt);
        wait_cycles(1);
        send_frame({2'b00, dy[8], dx[8], 1'b1, 1'b0, right, left}, 1'b0);
        send_frame(dx[7:0], 1'b0);
        send_frame(dy[7:0], corrupt);
    endtask

    task automatic move_and_check(input logic signed [8:0] dx, input logic signed [8:0] dy,
                                  input logic left, input logic right);
        int target;
        target = strobe_count + 1;
        send_packet(dx, dy, left, right, 1'b0);
        while (strobe_count < target) @(negedge clk);
        // canvas takes the event one cycle after the strobe
        @(negedge clk);
        apply_model(dx, dy, left, right);
        check_value("o_cursor_x", 32'(cursor_x), 32'(model_x));
        check_value("o_cursor_y", 32'(cursor_y), 32'(model_y));
    endtask

    function automatic logic [23:0] expected_colour(input int px, input int py);
        int cx;
        int cy;
        cx = px >> CELL_SHIFT;
        cy = py >> CELL_SHIFT;
        if ((cx >= CANVAS_DIM) || (cy >= CANVAS_DIM)) begin
            return BACKGROUND_RGB;
        end
        if ((cx == model_x) && (cy == model_y)) begin
            return CURSOR_RGB;
        end
        if (model_ink[cy * CANVAS_DIM + cx]) begin
            return INK_RGB;
        end
        return PAPER_RGB;
    endfunction

    // whole visible frame against the scoreboard
    task automatic check_frame();
        @(negedge clk);
        while (vga_vs !== 1'b1) @(negedge clk);
        while (vga_vs !== 1'b0) @(negedge clk);
        for (int line = 0; line < V_ACTIVE; line++) begin
            // first visible pixel of the line
            while (!((vga_blank_n === 1'b1) && (vga_hs === 1'b1))) @(negedge clk);
            for (int col = 0; col < H_ACTIVE; col++) begin
                check_value($sformatf("pixel(%0d,%0d)", col, line),
                            32'({vga_r, vga_g, vga_b}), 32'(expected_colour(col, line)));
                check_value("o_vga_blank_n", 32'(vga_blank_n), 32'd1);
                @(negedge clk);
            end
        end
    endtask

    task automatic measure_sync_widths();
        int width;
        while (vga_hs !== 1'b1) @(negedge clk);
        while (vga_hs !== 1'b0) @(negedge clk);
        width = 0;
        while (vga_hs === 1'b0) begin
            width++;
            @(negedge clk);
        end
        check_value("o_vga_hs low cycles", 32'(width), 32'(H_SYNC));
        while (vga_vs !== 1'b1) @(negedge clk);
        while (vga_vs !== 1'b0) @(negedge clk);
        width = 0;
        while (vga_vs === 1'b0) begin
            width++;
            @(negedge clk);
        end
        check_value("o_vga_vs low cycles", 32'(width), 32'(V_SYNC * H_TOTAL));
    endtask

    task automatic reset_state();
        @(negedge clk);
        check_value("o_cursor_x", 32'(cursor_x), 32'(CANVAS_DIM / 2));
        check_value("o_cursor_y", 32'(cursor_y), 32'(CANVAS_DIM / 2));
        check_frame();
        measure_sync_widths();
    endtask

    task automatic random_moves();
        // both corners first to force clamping
        move_and_check(9'sd255, -9'sd256, 1'b0, 1'b0);
        move_and_check(-9'sd256, 9'sd255, 1'b0, 1'b0);
        for (int i = 0; i < 10; i++) begin
            move_and_check(random_motion(), random_motion(), 1'b0, 1'b0);
        end
    endtask

    task automatic ink_trail();
        // park at top left before painting
        move_and_check(-9'sd256, 9'sd255, 1'b0, 1'b0);
        move_and_check(9'sd8, 9'sd0, 1'b1, 1'b0);
        move_and_check(9'sd8, 9'sd0, 1'b1, 1'b0);
        move_and_check(9'sd0, -9'sd8, 1'b1, 1'b0);
        move_and_check(9'sd0, -9'sd4, 1'b1, 1'b0);
        move_and_check(-9'sd4, 9'sd0, 1'b1, 1'b0);
        move_and_check(9'sd8, 9'sd4, 1'b1, 1'b0);
        check_frame();
    endtask

    task automatic right_button_clear();
        // right wins over left
        move_and_check(9'sd4, 9'sd0, 1'b1, 1'b1);
        // step off the cell so stray ink under the old cursor would show
        move_and_check(9'sd8, 9'sd0, 1'b0, 1'b0);
        check_frame();
    endtask

    task automatic parity_error_drop();
        int strobes_before;
        int errors_before;
        strobes_before = strobe_count;
        errors_before  = error_pulse_count;
        send_packet(9'sd40, -9'sd40, 1'b0, 1'b0, 1'b1);
        while (error_pulse_count < errors_before + 1) @(negedge clk);
        @(negedge clk);
        check_value("o_ps2_error pulses", 32'(error_pulse_count), 32'(errors_before + 1));
        check_value("event strobes", 32'(strobe_count), 32'(strobes_before));
        check_value("o_cursor_x", 32'(cursor_x), 32'(model_x));
        check_value("o_cursor_y", 32'(cursor_y), 32'(model_y));
        move_and_check(random_motion(), random_motion(), 1'b0, 1'b0);
    endtask

    initial begin
        reset             = 1'b1;
        ps2_clk           = 1'b1;
        ps2_data          = 1'b1;
        error_count       = 0;
        check_count       = 0;
        strobe_count      = 0;
        error_pulse_count = 0;
        lfsr_state        = 32'hc127_c28a;
        model_x           = CANVAS_DIM / 2;
        model_y           = CANVAS_DIM / 2;
        foreach (model_ink[i]) model_ink[i] = 1'b0;
        wait_cycles(RESET_CYCLES);
        reset = 1'b0;

        reset_state();
        random_moves();
        ink_trail();
        right_button_clear();
        parity_error_drop();

        $display("checks %0d, errors %0d, strobes %0d, frame errors %0d",
                 check_count, error_count, strobe_count, error_pulse_count);
        if (error_count == 0) begin
            $display("Simulation PASSED");
        end else begin
            $display("Simulation FAILED");
        end
        $finish;
    end

endmodule

/* hw/digit_pad_top.sv */
`timescale 1ns/1ns

module digit_pad_top import digit_pad_pkg::*; #(
    parameter int CANVAS_DIM   = DEFAULT_CANVAS_DIM,
    parameter int CELL_SHIFT   = DEFAULT_CELL_SHIFT,
    parameter int MOTION_SHIFT = DEFAULT_MOTION_SHIFT,
    parameter int H_ACTIVE     = DEFAULT_H_ACTIVE,
    parameter int H_FRONT      = DEFAULT_H_FRONT,
    parameter int H_SYNC       = DEFAULT_H_SYNC,
    parameter int H_BACK       = DEFAULT_H_BACK,
    parameter int V_ACTIVE     = DEFAULT_V_ACTIVE,
    parameter int V_FRONT      = DEFAULT_V_FRONT,
    parameter int V_SYNC       = DEFAULT_V_SYNC,
    parameter int V_BACK       = DEFAULT_V_BACK
) (
    input  logic                          i_clk,
    input  logic                          i_reset,
    input  logic                          i_ps2_clk,
    input  logic                          i_ps2_data,
    output logic [7:0]                    o_vga_r,
    output logic [7:0]                    o_vga_g,
    output logic [7:0]                    o_vga_b,
    output logic                          o_vga_hs,
    output logic                          o_vga_vs,
    output logic                          o_vga_blank_n,
    output logic [$clog2(CANVAS_DIM)-1:0] o_cursor_x,
    output logic [$clog2(CANVAS_DIM)-1:0] o_cursor_y,
    output logic                          o_ps2_error
);

    mouse_event_if mouse_events ();
    raster_if      raster ();

    // handwriting vector, row-major
    logic [CANVAS_DIM*CANVAS_DIM-1:0] bitmap;
    pixel_t                           pixel;

    // mouse packets in
    ps2_packet_decoder ps2_packet_decoder0 (
        .i_clk         (i_clk),
        .i_reset       (i_reset),
        .i_ps2_clk     (i_ps2_clk),
        .i_ps2_data    (i_ps2_data),
        .o_frame_error (o_ps2_error),
        .event_bus     (mouse_events.source)
    );

    sketch_canvas #(
        .CANVAS_DIM   (CANVAS_DIM),
        .MOTION_SHIFT (MOTION_SHIFT)
    ) sketch_canvas0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .event_bus  (mouse_events.sink),
        .o_bitmap   (bitmap),
        .o_cursor_x (o_cursor_x),
        .o_cursor_y (o_cursor_y)
    );

    // beam timing
    vga_raster #(
        .H_ACTIVE (H_ACTIVE),
        .H_FRONT  (H_FRONT),
        .H_SYNC   (H_SYNC),
        .H_BACK   (H_BACK),
        .V_ACTIVE (V_ACTIVE),
        .V_FRONT  (V_FRONT),
        .V_SYNC   (V_SYNC),
        .V_BACK   (V_BACK)
    ) vga_raster0 (
        .i_clk   (i_clk),
        .i_reset (i_reset),
        .raster  (raster.source)
    );

    canvas_overlay #(
        .CANVAS_DIM (CANVAS_DIM),
        .CELL_SHIFT (CELL_SHIFT)
    ) canvas_overlay0 (
        .i_clk      (i_clk),
        .i_reset    (i_reset),
        .i_bitmap   (bitmap),
        .i_cursor_x (o_cursor_x),
        .i_cursor_y (o_cursor_y),
        .raster     (raster.sink),
        .o_pixel    (pixel),
        .o_blank_n  (o_vga_blank_n),
        .o_hsync_n  (o_vga_hs),
        .o_vsync_n  (o_vga_vs)
    );

    // split the pixel onto the dac pins
    assign o_vga_r = pixel.red;
    assign o_vga_g = pixel.green;
    assign o_vga_b = pixel.blue;

endmodule

/* hw/canvas_overlay.sv */
`timescale 1ns/1ns

module canvas_overlay import digit_pad_pkg::*; #(
    parameter int CANVAS_DIM = DEFAULT_CANVAS_DIM,
    parameter int CELL_SHIFT = DEFAULT_CELL_SHIFT
) (
    input  logic                             i_clk,
    input  logic                             i_reset,
    input  logic [CANVAS_DIM*CANVAS_DIM-1:0] i_bitmap,
    input  logic [$clog2(CANVAS_DIM)-1:0]    i_cursor_x,
    input  logic [$clog2(CANVAS_DIM)-1:0]    i_cursor_y,
    raster_if.sink                           raster,
    output pixel_t                           o_pixel,
    output logic                             o_blank_n,
    output logic                             o_hsync_n,
    output logic                             o_vsync_n
);

    localparam int CELLS       = CANVAS_DIM * CANVAS_DIM;
    localparam int CURSOR_BITS = $clog2(CANVAS_DIM);
    localparam int INDEX_BITS  = $clog2(CELLS);

    coord_t                 cell_x;
    coord_t                 cell_y;
    logic [CURSOR_BITS-1:0] col;
    logic [CURSOR_BITS-1:0] row;
    logic [INDEX_BITS-1:0]  cell_index;
    logic                   in_grid;
    logic                   at_cursor;
    logic                   inked;
    pixel_t                 colour;

    always_comb begin
        // square cells of 2**CELL_SHIFT pixels per side
        cell_x     = raster.x >> CELL_SHIFT;
        cell_y     = raster.y >> CELL_SHIFT;
        col        = cell_x[CURSOR_BITS-1:0];
        row        = cell_y[CURSOR_BITS-1:0];
        in_grid    = (cell_x < coord_t'(CANVAS_DIM)) && (cell_y < coord_t'(CANVAS_DIM));
        // only meaningful inside the grid
        cell_index = INDEX_BITS'(row) * INDEX_BITS'(CANVAS_DIM) + INDEX_BITS'(col);
        at_cursor  = in_grid && (col == i_cursor_x) && (row == i_cursor_y);
        inked      = in_grid && i_bitmap[cell_index];

        // blanking and off-grid first, then cursor over ink over paper
        if (!raster.active || !in_grid) begin
            colour = BACKGROUND;
        end else if (at_cursor) begin
            colour = CURSOR_COLOR;
        end else if (inked) begin
            colour = INK_COLOR;
        end else begin
            colour = PAPER_COLOR;
        end
    end

    // syncs and blank ride along with the pixel
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_pixel   <= BACKGROUND;
            o_blank_n <= 1'b0;
            o_hsync_n <= 1'b1;
            o_vsync_n <= 1'b1;
        end else begin
            o_pixel   <= colour;
            o_blank_n <= raster.active;
            o_hsync_n <= raster.hsync_n;
            o_vsync_n <= raster.vsync_n;
        end
    end

endmodule

/* hw/vga_raster.sv */
`timescale 1ns/1ns

module vga_raster import digit_pad_pkg::*; #(
    parameter int H_ACTIVE = DEFAULT_H_ACTIVE,
    parameter int H_FRONT  = DEFAULT_H_FRONT,
    parameter int H_SYNC   = DEFAULT_H_SYNC,
    parameter int H_BACK   = DEFAULT_H_BACK,
    parameter int V_ACTIVE = DEFAULT_V_ACTIVE,
    parameter int V_FRONT  = DEFAULT_V_FRONT,
    parameter int V_SYNC   = DEFAULT_V_SYNC,
    parameter int V_BACK   = DEFAULT_V_BACK
) (
    input  logic     i_clk,
    input  logic     i_reset,
    raster_if.source raster
);

    // full line and frame lengths, blanking included
    localparam coord_t H_LAST     = coord_t'(H_ACTIVE + H_FRONT + H_SYNC + H_BACK - 1);
    localparam coord_t V_LAST     = coord_t'(V_ACTIVE + V_FRONT + V_SYNC + V_BACK - 1);
    // sync windows, end exclusive
    localparam coord_t H_SYNC_BEG = coord_t'(H_ACTIVE + H_FRONT);
    localparam coord_t H_SYNC_END = coord_t'(H_ACTIVE + H_FRONT + H_SYNC);
    localparam coord_t V_SYNC_BEG = coord_t'(V_ACTIVE + V_FRONT);
    localparam coord_t V_SYNC_END = coord_t'(V_ACTIVE + V_FRONT + V_SYNC);

    coord_t next_x;
    coord_t next_y;

    // next position, flags below follow it so all outputs line up
    always_comb begin
        next_x = raster.x + coord_t'(1);
        next_y = raster.y;
        if (raster.x == H_LAST) begin
            next_x = '0;
            // line wrap steps the frame counter
            if (raster.y == V_LAST) begin
                next_y = '0;
            end else begin
                next_y = raster.y + coord_t'(1);
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            // top-left visible pixel, no sync pulse
            raster.x       <= '0;
            raster.y       <= '0;
            raster.active  <= 1'b1;
            raster.hsync_n <= 1'b1;
            raster.vsync_n <= 1'b1;
        end else begin
            raster.x       <= next_x;
            raster.y       <= next_y;
            raster.active  <= (next_x < coord_t'(H_ACTIVE)) && (next_y < coord_t'(V_ACTIVE));
            raster.hsync_n <= !((next_x >= H_SYNC_BEG) && (next_x < H_SYNC_END));
            raster.vsync_n <= !((next_y >= V_SYNC_BEG) && (next_y < V_SYNC_END));
        end
    end

    // vertical sync only starts together with a new line
    assert property (@(posedge i_clk) disable iff (i_reset)
        $fell(raster.vsync_n) |-> (raster.x == '0));

endmodule

/* hw/sketch_canvas.sv */
`timescale 1ns/1ns

module sketch_canvas import digit_pad_pkg::*; #(
    parameter int CANVAS_DIM   = DEFAULT_CANVAS_DIM,
    parameter int MOTION_SHIFT = DEFAULT_MOTION_SHIFT
) (
    input  logic                            i_clk,
    input  logic                            i_reset,
    mouse_event_if.sink                     event_bus,
    output logic [CANVAS_DIM*CANVAS_DIM-1:0] o_bitmap,
    output logic [$clog2(CANVAS_DIM)-1:0]   o_cursor_x,
    output logic [$clog2(CANVAS_DIM)-1:0]   o_cursor_y
);

    localparam int CELLS       = CANVAS_DIM * CANVAS_DIM;
    localparam int CURSOR_BITS = $clog2(CANVAS_DIM);
    localparam int INDEX_BITS  = $clog2(CELLS);
    // room for cursor plus the largest step of either sign
    localparam int SUM_BITS    = 12;

    typedef logic signed [SUM_BITS-1:0] sum_t;

    localparam sum_t MAX_POS = sum_t'(CANVAS_DIM - 1);

    sum_t                  step_x;
    sum_t                  step_y;
    sum_t                  sum_x;
    sum_t                  sum_y;
    logic [CURSOR_BITS-1:0] new_x;
    logic [CURSOR_BITS-1:0] new_y;
    logic [INDEX_BITS-1:0]  ink_index;

    // keep a position inside 0 .. CANVAS_DIM-1
    function automatic logic [CURSOR_BITS-1:0] clamp(input sum_t value);
        if (value < 0) begin
            return '0;
        end
        if (value > MAX_POS) begin
            return CURSOR_BITS'(CANVAS_DIM - 1);
        end
        return value[CURSOR_BITS-1:0];
    endfunction

    always_comb begin
        // counts to cells, arithmetic so negative steps round down
        step_x = sum_t'(motion_t'(event_bus.dx >>> MOTION_SHIFT));
        step_y = sum_t'(motion_t'(event_bus.dy >>> MOTION_SHIFT));
        sum_x  = sum_t'(o_cursor_x) + step_x;
        // mouse y grows upward, rows grow downward
        sum_y  = sum_t'(o_cursor_y) - step_y;
        new_x  = clamp(sum_x);
        new_y  = clamp(sum_y);
        // row-major cell number
        ink_index = INDEX_BITS'(new_y) * INDEX_BITS'(CANVAS_DIM) + INDEX_BITS'(new_x);
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_bitmap   <= '0;
            o_cursor_x <= CURSOR_BITS'(CANVAS_DIM / 2);
            o_cursor_y <= CURSOR_BITS'(CANVAS_DIM / 2);
        end else if (event_bus.strobe) begin
            o_cursor_x <= new_x;
            o_cursor_y <= new_y;
            if (event_bus.right) begin
                // right button wipes, wins over left
                o_bitmap <= '0;
            end else if (event_bus.left) begin
                // paint under the moved cursor
                o_bitmap[ink_index] <= 1'b1;
            end
        end
    end

    // cursor never leaves the grid whatever the mouse sends
    assert property (@(posedge i_clk) disable iff (i_reset)
        (o_cursor_x < CANVAS_DIM) && (o_cursor_y < CANVAS_DIM));

endmodule

/* hw/ps2_packet_decoder.sv */
`timescale 1ns/1ns

module ps2_packet_decoder import digit_pad_pkg::*; (
    input  logic          i_clk,
    input  logic          i_reset,
    input  logic          i_ps2_clk,
    input  logic          i_ps2_data,
    output logic          o_frame_error,
    mouse_event_if.source event_bus
);

    // two-flop synchronisers, idle level is high
    logic [1:0]  ps2_clk_sync;
    logic [1:0]  ps2_data_sync;
    logic        ps2_clk_prev;
    logic        bit_sample;
    // frame assembly
    logic [3:0]  bit_count;
    logic [9:0]  shift_reg;
    logic [10:0] frame;
    logic [7:0]  byte_data;
    logic        frame_done;
    logic        frame_ok;
    // packet assembly
    logic [1:0]  byte_count;
    logic [7:0]  header;
    logic [7:0]  x_byte;

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            ps2_clk_sync  <= 2'b11;
            ps2_data_sync <= 2'b11;
            ps2_clk_prev  <= 1'b1;
        end else begin
            ps2_clk_sync  <= {ps2_clk_sync[0], i_ps2_clk};
            ps2_data_sync <= {ps2_data_sync[0], i_ps2_data};
            ps2_clk_prev  <= ps2_clk_sync[1];
        end
    end

    // falling edge of the synchronised clock samples one bit
    assign bit_sample = ps2_clk_prev & ~ps2_clk_sync[1];

    // current bit joins the ten already shifted in
    assign frame      = {ps2_data_sync[1], shift_reg};
    assign byte_data  = frame[8:1];
    assign frame_done = bit_sample && (bit_count == 4'd10);
    // start low and stop high with odd parity over data and parity bit
    assign frame_ok   = !frame[0] && (^frame[9:1]) && frame[10];

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            bit_count        <= '0;
            byte_count       <= '0;
            event_bus.strobe <= 1'b0;
            o_frame_error    <= 1'b0;
        end else begin
            event_bus.strobe <= 1'b0;
            o_frame_error    <= 1'b0;
            if (frame_done) begin
                bit_count <= '0;
                if (!frame_ok) begin
                    // bad frame drops the whole packet
                    o_frame_error <= 1'b1;
                    byte_count    <= '0;
                end else if (byte_count == 2'd2) begin
                    event_bus.strobe <= 1'b1;
                    byte_count       <= '0;
                end else if ((byte_count == 2'd0) && !frame[4]) begin
                    // header without bit 3 is dropped without an error
                    byte_count <= '0;
                end else begin
                    byte_count <= byte_count + 2'd1;
                end
            end else if (bit_sample) begin
                bit_count <= bit_count + 4'd1;
            end
        end
    end

    always_ff @(posedge i_clk) begin
        if (bit_sample) begin
            shift_reg <= {ps2_data_sync[1], shift_reg[9:1]};
        end
        if (frame_done && frame_ok) begin
            case (byte_count)
                2'd0: header <= byte_data;
                2'd1: x_byte <= byte_data;
                default: begin
                    // sign bits live in the header byte
                    event_bus.dx    <= motion_t'({header[4], x_byte});
                    event_bus.dy    <= motion_t'({header[5], byte_data});
                    event_bus.left  <= header[0];
                    event_bus.right <= header[1];
                end
            endcase
        end
    end

    // one strobe cycle per packet
    assert property (@(posedge i_clk) disable iff (i_reset)
        event_bus.strobe |=> !event_bus.strobe);

endmodule

/* hw/raster_if.sv */
`timescale 1ns/1ns

interface raster_if import digit_pad_pkg::*; ();

    // current beam position, counts blanking too
    coord_t x;
    coord_t y;
    // inside the visible area
    logic   active;
    // syncs, low during the pulse
    logic   hsync_n;
    logic   vsync_n;

    // raster generator side, all registered
    modport source (
        output x, y, active, hsync_n, vsync_n
    );

    // overlay side
    modport sink (
        input x, y, active, hsync_n, vsync_n
    );

endinterface

/* hw/mouse_event_if.sv */
`timescale 1ns/1ns

interface mouse_event_if import digit_pad_pkg::*; ();

    // one-cycle pulse per good packet, no back-pressure
    logic    strobe;
    // raw counts, dy positive upward
    motion_t dx;
    motion_t dy;
    // button state at the time of the packet
    logic    left;
    logic    right;

    // packet decoder side
    modport source (
        output strobe, dx, dy, left, right
    );

    // canvas side, takes every event on arrival
    modport sink (
        input strobe, dx, dy, left, right
    );

endinterface

/* hw/digit_pad_pkg.sv */
package digit_pad_pkg;

    // one pixel as driven onto the vga dac
    typedef struct packed {
        logic [7:0] red;
        logic [7:0] green;
        logic [7:0] blue;
    } pixel_t;

    // mouse displacement, sign bit comes from the packet header
    typedef logic signed [8:0] motion_t;

    // raster coordinate, wide enough for the full 800 x 525 frame
    typedef logic [10:0] coord_t;

    // 30 x 30 cells, 16 pixels per side gives a 480 pixel square
    localparam int DEFAULT_CANVAS_DIM   = 30;
    localparam int DEFAULT_CELL_SHIFT   = 4;
    // four mouse counts per cell step
    localparam int DEFAULT_MOTION_SHIFT = 2;

    // 640 x 480 at 25 MHz pixel clock
    localparam int DEFAULT_H_ACTIVE = 640;
    localparam int DEFAULT_H_FRONT  = 16;
    localparam int DEFAULT_H_SYNC   = 96;
    localparam int DEFAULT_H_BACK   = 48;
    localparam int DEFAULT_V_ACTIVE = 480;
    localparam int DEFAULT_V_FRONT  = 10;
    localparam int DEFAULT_V_SYNC   = 2;
    localparam int DEFAULT_V_BACK   = 33;

    // colour table for the overlay
    localparam pixel_t INK_COLOR    = '{red: 8'd255, green: 8'd255, blue: 8'd255};
    localparam pixel_t CURSOR_COLOR = '{red: 8'd255, green: 8'd0, blue: 8'd0};
    localparam pixel_t PAPER_COLOR  = '{red: 8'd40, green: 8'd40, blue: 8'd40};
    localparam pixel_t BACKGROUND   = '{red: 8'd0, green: 8'd0, blue: 8'd0};

endpackage
